// ==== src/rvPkg.sv ====
`default_nettype none

package rvPkg;

	// data and address width
	localparam int xlen = 32;

	// supported RV32I major opcodes
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opReg    = 7'b0110011;

	// data RAM geometry, in words
	localparam int ramWords    = 256;
	localparam int ramAddrBits = 8;

	typedef enum logic [3:0] {
		aluAdd   = 4'd0,
		aluSub   = 4'd1,
		aluAnd   = 4'd2,
		aluOr    = 4'd3,
		aluXor   = 4'd4,
		aluSlt   = 4'd5,
		aluSll   = 4'd6,
		aluSrl   = 4'd7,
		aluPassB = 4'd8
	} aluOp_t;

	// decoded control, one per instruction
	typedef struct packed {
		logic   regWrite;
		logic   memRead;
		logic   memWrite;
		logic   branch;
		logic   branchNe;
		logic   jump;
		logic   aluSrcImm;
		aluOp_t aluOp;
		logic   legal;
	} ctrl_t;

endpackage

`default_nettype wire

// ==== src/wbBus.sv ====
`default_nettype none
`timescale 1ns/1ps

interface wbBus;
	import rvPkg::*;

	logic [xlen-1:0] adr;
	logic [xlen-1:0] datW;
	logic [xlen-1:0] datR;
	logic            we;
	logic [3:0]      sel;
	logic            cyc;
	logic            stb;
	logic            ack;

	modport master (
		output adr, datW, we, sel, cyc, stb,
		input  datR, ack
	);

	modport slave (
		input  adr, datW, we, sel, cyc, stb,
		output datR, ack
	);

endinterface

`default_nettype wire

// ==== src/instDecoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module instDecoder (
	input  logic [rvPkg::xlen-1:0] inst,
	output rvPkg::ctrl_t           ctrl,
	output logic [rvPkg::xlen-1:0] imm
);
	import rvPkg::*;

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [xlen-1:0] immI;
	logic [xlen-1:0] immS;
	logic [xlen-1:0] immB;
	logic [xlen-1:0] immU;
	logic [xlen-1:0] immJ;
	logic            okReg;
	logic            okImm;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// only sub carries a nonzero funct7
	assign okReg = (funct3 != 3'b011) &&
		((funct7 == 7'b0000000) || (funct7 == 7'b0100000 && funct3 == 3'b000));
	assign okImm = (funct3 == 3'b000) || (funct3 == 3'b010) || (funct3 == 3'b100) ||
		(funct3 == 3'b110) || (funct3 == 3'b111);

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluAdd;
		imm = '0;
		case (opcode)
			opReg: begin
				case (funct3)
					3'b000: ctrl.aluOp = funct7[5] ? aluSub : aluAdd;
					3'b001: ctrl.aluOp = aluSll;
					3'b010: ctrl.aluOp = aluSlt;
					3'b100: ctrl.aluOp = aluXor;
					3'b101: ctrl.aluOp = aluSrl;
					3'b110: ctrl.aluOp = aluOr;
					default: ctrl.aluOp = aluAnd;
				endcase
				ctrl.regWrite = okReg;
				ctrl.legal = okReg;
			end
			opImm: begin
				case (funct3)
					3'b010: ctrl.aluOp = aluSlt;
					3'b100: ctrl.aluOp = aluXor;
					3'b110: ctrl.aluOp = aluOr;
					3'b111: ctrl.aluOp = aluAnd;
					default: ctrl.aluOp = aluAdd;
				endcase
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = okImm;
				ctrl.legal = okImm;
				imm = immI;
			end
			opLui: begin
				ctrl.aluOp = aluPassB;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.legal = 1'b1;
				imm = immU;
			end
			// word accesses only
			opLoad: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memRead = (funct3 == 3'b010);
				ctrl.regWrite = (funct3 == 3'b010);
				ctrl.legal = (funct3 == 3'b010);
				imm = immI;
			end
			opStore: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = (funct3 == 3'b010);
				ctrl.legal = (funct3 == 3'b010);
				imm = immS;
			end
			opBranch: begin
				ctrl.branch = (funct3[2:1] == 2'b00);
				ctrl.branchNe = funct3[0];
				ctrl.legal = (funct3[2:1] == 2'b00);
				imm = immB;
			end
			opJal: begin
				ctrl.jump = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.legal = 1'b1;
				imm = immJ;
			end
			default: ctrl.legal = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`default_nettype none
`timescale 1ns/1ps

module regFile (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   we,
	input  logic [4:0]             rs1,
	input  logic [4:0]             rs2,
	input  logic [4:0]             rd,
	input  logic [rvPkg::xlen-1:0] wdata,
	output logic [rvPkg::xlen-1:0] rdata1,
	output logic [rvPkg::xlen-1:0] rdata2
);
	import rvPkg::*;

	// x0 has no storage
	logic [xlen-1:0] regs [1:31];

	assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

endmodule

`default_nettype wire

// ==== src/execUnit.sv ====
`default_nettype none
`timescale 1ns/1ps

module execUnit (
	input  rvPkg::ctrl_t           ctrl,
	input  logic [rvPkg::xlen-1:0] imm,
	input  logic [rvPkg::xlen-1:0] pc,
	input  logic [rvPkg::xlen-1:0] rdata1,
	input  logic [rvPkg::xlen-1:0] rdata2,
	input  logic [rvPkg::xlen-1:0] loadData,
	output logic [rvPkg::xlen-1:0] nextPc,
	output logic [rvPkg::xlen-1:0] memAddr,
	output logic [rvPkg::xlen-1:0] wdata,
	output logic [rvPkg::xlen-1:0] storeData
);
	import rvPkg::*;

	logic [xlen-1:0] opB;
	logic [xlen-1:0] aluResult;
	logic [xlen-1:0] pcPlus4;
	logic [xlen-1:0] target;
	logic            taken;

	assign opB = ctrl.aluSrcImm ? imm : rdata2;

	always_comb begin
		case (ctrl.aluOp)
			aluAdd:   aluResult = rdata1 + opB;
			aluSub:   aluResult = rdata1 - opB;
			aluAnd:   aluResult = rdata1 & opB;
			aluOr:    aluResult = rdata1 | opB;
			aluXor:   aluResult = rdata1 ^ opB;
			aluSlt:   aluResult = {31'b0, $signed(rdata1) < $signed(opB)};
			aluSll:   aluResult = rdata1 << opB[4:0];
			aluSrl:   aluResult = rdata1 >> opB[4:0];
			aluPassB: aluResult = opB;
			default:  aluResult = '0;
		endcase
	end

	// beq and bne share one compare
	assign taken = ctrl.branch && ((rdata1 == rdata2) != ctrl.branchNe);

	assign pcPlus4 = pc + 32'd4;
	assign target = pc + imm;

	always_comb begin
		nextPc = (ctrl.jump || taken) ? target : pcPlus4;
		assert final ($isunknown(nextPc) || nextPc[1:0] == 2'b00)
			else $error("misaligned next pc %h", nextPc);
	end

	assign memAddr = aluResult;
	assign storeData = rdata2;

	// jal links pc+4
	assign wdata = ctrl.memRead ? loadData : (ctrl.jump ? pcPlus4 : aluResult);

endmodule

`default_nettype wire

// ==== src/loadStoreUnit.sv ====
`default_nettype none
`timescale 1ns/1ps

module loadStoreUnit (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   memRead,
	input  logic                   memWrite,
	input  logic [rvPkg::xlen-1:0] addr,
	input  logic [rvPkg::xlen-1:0] storeData,
	output logic [rvPkg::xlen-1:0] loadData,
	output logic                   stall,
	wbBus.master                   wb
);
	import rvPkg::*;

	logic req;
	logic active;
	logic done;

	assign req = memRead || memWrite;

	// done keeps cyc low for one cycle after ack,
	// so back to back accesses see an idle cycle
	assign active = req && !done;

	assign wb.cyc  = active;
	assign wb.stb  = active;
	assign wb.we   = memWrite;
	assign wb.adr  = addr;
	assign wb.datW = storeData;
	assign wb.sel  = 4'hf;

	assign loadData = wb.datR;

	// pc moves only in the ack cycle
	assign stall = req && !wb.ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			done <= 1'b0;
		end else begin
			done <= wb.ack;
		end
	end

	// request held steady until the slave acks
	reqHeldUntilAck: assert property (@(posedge clk) disable iff (rst)
		wb.stb && !wb.ack |=> wb.stb && $stable(wb.adr) && $stable(wb.we))
		else $error("request changed before ack");

endmodule

`default_nettype wire

// ==== src/dataRam.sv ====
`default_nettype none
`timescale 1ns/1ps

module dataRam (
	input  logic clk,
	input  logic rst,
	wbBus.slave  wb
);
	import rvPkg::*;

	logic [xlen-1:0]        mem [ramWords];
	logic [ramAddrBits-1:0] idx;
	logic                   take;

	assign idx = wb.adr[ramAddrBits+1:2];

	// new request, not the tail of the last one
	assign take = wb.cyc && wb.stb && !wb.ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb.ack <= 1'b0;
		end else begin
			wb.ack <= take;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			if (wb.we) begin
				for (int b = 0; b < 4; b++) begin
					if (wb.sel[b]) begin
						mem[idx][8*b +: 8] <= wb.datW[8*b +: 8];
					end
				end
			end
			wb.datR <= mem[idx];
		end
	end

	// master ends the cycle right after ack
	cycEndsAfterAck: assert property (@(posedge clk) disable iff (rst)
		wb.ack |=> !wb.cyc)
		else $error("cyc still high in the cycle after ack");

endmodule

`default_nettype wire

// ==== src/rvCore.sv ====
`default_nettype none
`timescale 1ns/1ps

module rvCore (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [rvPkg::xlen-1:0] inst,
	output logic [rvPkg::xlen-1:0] pc,
	output logic                   retireValid,
	output logic [4:0]             retireRd,
	output logic [rvPkg::xlen-1:0] retireData
);
	import rvPkg::*;

	ctrl_t           ctrl;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] rdata1;
	logic [xlen-1:0] rdata2;
	logic [xlen-1:0] nextPc;
	logic [xlen-1:0] memAddr;
	logic [xlen-1:0] wdata;
	logic [xlen-1:0] storeData;
	logic [xlen-1:0] loadData;
	logic [4:0]      rd;
	logic            stall;
	logic            regWe;

	wbBus wb ();

	assign rd = inst[11:7];

	// no write until the bus access completes
	assign regWe = ctrl.regWrite && !stall;

	assign retireValid = regWe && (rd != 5'd0);
	assign retireRd = rd;
	assign retireData = wdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= nextPc;
		end
	end

	instDecoder decoder (
		.inst (inst),
		.ctrl (ctrl),
		.imm  (imm)
	);

	regFile regs (
		.clk    (clk),
		.rst    (rst),
		.we     (regWe),
		.rs1    (inst[19:15]),
		.rs2    (inst[24:20]),
		.rd     (rd),
		.wdata  (wdata),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	execUnit exec (
		.ctrl      (ctrl),
		.imm       (imm),
		.pc        (pc),
		.rdata1    (rdata1),
		.rdata2    (rdata2),
		.loadData  (loadData),
		.nextPc    (nextPc),
		.memAddr   (memAddr),
		.wdata     (wdata),
		.storeData (storeData)
	);

	loadStoreUnit lsu (
		.clk       (clk),
		.rst       (rst),
		.memRead   (ctrl.memRead),
		.memWrite  (ctrl.memWrite),
		.addr      (memAddr),
		.storeData (storeData),
		.loadData  (loadData),
		.stall     (stall),
		.wb        (wb.master)
	);

	dataRam ram (
		.clk (clk),
		.rst (rst),
		.wb  (wb.slave)
	);

endmodule

`default_nettype wire

// ==== test/rvCoreTb.sv ====
`default_nettype none
`timescale 1ns/1ps

module rvCoreTb;
	import rvPkg::*;

	localparam int halfPeriod = 20;
	localparam int resetCycles = 5;
	// addi x0, x0, 0
	localparam logic [31:0] nop = 32'h0000_0013;

	logic        clk;
	logic        rst;
	logic [31:0] inst;
	logic [31:0] pc;
	logic        retireValid;
	logic [4:0]  retireRd;
	logic [31:0] retireData;

	// program words with cycles spent at each pc, 0 for skipped words
	logic [31:0] progInst [$];
	int          progCycles [$];
	// retire records in order
	logic [4:0]  expRd [$];
	logic [31:0] expData [$];

	int          errors;
	int          retireIdx;
	int          cycles;
	int          limit;
	int          heldCycles;
	logic [31:0] prevPc;
	logic [31:0] progEnd;
	logic        finished;
	logic        timedOut;

	rvCore i_rvCore (
		.clk         (clk),
		.rst         (rst),
		.inst        (inst),
		.pc          (pc),
		.retireValid (retireValid),
		.retireRd    (retireRd),
		.retireData  (retireData)
	);

	initial clk = 1'b0;
	always #halfPeriod clk = ~clk;

	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opReg};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opcode);
		return {imm, rs1, f3, rd, opcode};
	endfunction

	function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	// instruction at a byte address, nop past the end
	function automatic logic [31:0] fetch(input logic [31:0] addr);
		int idx;
		if ($isunknown(addr)) begin
			return nop;
		end
		idx = int'(addr[31:2]);
		if (idx < progInst.size()) begin
			return progInst[idx];
		end
		return nop;
	endfunction

	task automatic addInst(input logic [31:0] word, input int held);
		progInst.push_back(word);
		progCycles.push_back(held);
	endtask

	task automatic addRetire(input logic [4:0] rd, input logic [31:0] data);
		expRd.push_back(rd);
		expData.push_back(data);
	endtask

	task automatic buildProgram;
		addInst(iType(12'd5, 5'd0, 3'b000, 5'd1, opImm), 1);
		addInst(iType(12'hffd, 5'd0, 3'b000, 5'd2, opImm), 1);
		addInst(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1);
		addInst(rType(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 1);
		addInst(rType(7'h00, 5'd2, 5'd1, 3'b111, 5'd5), 1);
		addInst(rType(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), 1);
		addInst(rType(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 1);
		addInst(rType(7'h00, 5'd1, 5'd2, 3'b010, 5'd8), 1);
		addInst(rType(7'h00, 5'd2, 5'd1, 3'b010, 5'd9), 1);
		addInst(rType(7'h00, 5'd1, 5'd1, 3'b001, 5'd10), 1);
		addInst(rType(7'h00, 5'd1, 5'd2, 3'b101, 5'd11), 1);
		addInst({20'h12345, 5'd12, opLui}, 1);
		// write to x0, then read x0
		addInst(iType(12'd7, 5'd1, 3'b000, 5'd0, opImm), 1);
		addInst(rType(7'h00, 5'd1, 5'd0, 3'b000, 5'd13), 1);
		addInst(sType(12'd16, 5'd12, 5'd0), 2);
		addInst(iType(12'h678, 5'd12, 3'b000, 5'd14, opImm), 1);
		addInst(iType(12'd16, 5'd0, 3'b010, 5'd15, opLoad), 2);
		// beq and bne taken, then both not taken
		addInst(bType(13'd8, 5'd13, 5'd1, 3'b000), 1);
		addInst(iType(12'd1, 5'd0, 3'b000, 5'd16, opImm), 0);
		addInst(bType(13'd8, 5'd2, 5'd1, 3'b001), 1);
		addInst(iType(12'd2, 5'd0, 3'b000, 5'd16, opImm), 0);
		addInst(bType(13'd8, 5'd2, 5'd1, 3'b000), 1);
		addInst(iType(12'd3, 5'd0, 3'b000, 5'd17, opImm), 1);
		addInst(bType(13'd8, 5'd13, 5'd1, 3'b001), 1);
		addInst(jType(21'd8, 5'd18), 1);
		addInst(iType(12'd9, 5'd0, 3'b000, 5'd19, opImm), 0);
		addInst(rType(7'h00, 5'd14, 5'd15, 3'b000, 5'd20), 1);
		addInst(iType(12'hfff, 5'd20, 3'b100, 5'd21, opImm), 1);
		addInst(iType(12'hffe, 5'd2, 3'b010, 5'd22, opImm), 1);
		addInst(iType(12'h0f0, 5'd1, 3'b110, 5'd23, opImm), 1);
		addInst(iType(12'h0ff, 5'd7, 3'b111, 5'd24, opImm), 1);

		addRetire(5'd1, 32'h0000_0005);
		addRetire(5'd2, 32'hffff_fffd);
		addRetire(5'd3, 32'h0000_0002);
		addRetire(5'd4, 32'h0000_0008);
		addRetire(5'd5, 32'h0000_0005);
		addRetire(5'd6, 32'hffff_fffd);
		addRetire(5'd7, 32'hffff_fff8);
		addRetire(5'd8, 32'h0000_0001);
		addRetire(5'd9, 32'h0000_0000);
		addRetire(5'd10, 32'h0000_00a0);
		addRetire(5'd11, 32'h07ff_ffff);
		addRetire(5'd12, 32'h1234_5000);
		addRetire(5'd13, 32'h0000_0005);
		addRetire(5'd14, 32'h1234_5678);
		addRetire(5'd15, 32'h1234_5000);
		addRetire(5'd17, 32'h0000_0003);
		addRetire(5'd18, 32'h0000_0064);
		addRetire(5'd20, 32'h2468_a678);
		addRetire(5'd21, 32'hdb97_5987);
		addRetire(5'd22, 32'h0000_0001);
		addRetire(5'd23, 32'h0000_00f5);
		addRetire(5'd24, 32'h0000_00f8);
	endtask

	task automatic checkRetire;
		if (retireValid === 1'b1) begin
			if (retireIdx >= expRd.size()) begin
				$display("unexpected retire to x%0d after the last expected record", retireRd);
				errors++;
			end else begin
				if (retireRd !== expRd[retireIdx]) begin
					$display("** Error: retireRd = %h, expected %h (record %0d)",
						retireRd, expRd[retireIdx], retireIdx);
					errors++;
				end
				if (retireData !== expData[retireIdx]) begin
					$display("** Error: retireData = %h, expected %h (record %0d)",
						retireData, expData[retireIdx], retireIdx);
					errors++;
				end
				retireIdx++;
			end
		end
	endtask

	// memory instructions hold pc one extra cycle
	task automatic checkPcHold;
		int idx;
		if (pc === prevPc) begin
			heldCycles++;
		end else begin
			idx = int'(prevPc[31:2]);
			if (idx >= progCycles.size() || progCycles[idx] != heldCycles) begin
				$display("** Error: cycles at pc %h = %h, expected %h",
					prevPc, heldCycles, (idx < progCycles.size()) ? progCycles[idx] : 0);
				errors++;
			end
			prevPc = pc;
			heldCycles = 1;
		end
	endtask

	initial begin
		rst = 1'b1;
		inst = nop;
		errors = 0;
		retireIdx = 0;
		cycles = 0;
		heldCycles = 0;
		prevPc = '0;
		finished = 1'b0;
		timedOut = 1'b0;
		buildProgram();
		progEnd = 32'(4 * progInst.size());
		limit = 2 * progInst.size() + resetCycles + 20;

		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		if (pc !== 32'h0) begin
			$display("** Error: pc = %h after reset, expected %h", pc, 32'h0);
			errors++;
		end
		if (retireValid !== 1'b0) begin
			$display("** Error: retireValid = %h after reset, expected %h", retireValid, 1'b0);
			errors++;
		end
		rst = 1'b0;

		while (!finished && !timedOut) begin
			inst = fetch(pc);
			// outputs settle well before the next rising edge
			#(halfPeriod / 2);
			checkRetire();
			checkPcHold();
			cycles++;
			if (pc === progEnd) begin
				finished = 1'b1;
			end else if (cycles >= limit) begin
				timedOut = 1'b1;
			end
			@(negedge clk);
		end

		if (timedOut) begin
			$display("timeout after %0d cycles with %0d of %0d retire records seen",
				cycles, retireIdx, expRd.size());
			errors++;
		end else if (retireIdx != expRd.size()) begin
			$display("program ended with %0d of %0d retire records seen",
				retireIdx, expRd.size());
			errors++;
		end

		$display("retires checked: %0d of %0d, errors: %0d", retireIdx, expRd.size(), errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
src/rvPkg.sv
src/wbBus.sv
src/instDecoder.sv
src/regFile.sv
src/execUnit.sv
src/loadStoreUnit.sv
src/dataRam.sv
src/rvCore.sv
test/rvCoreTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module rvCoreTb -f sources.f -o rvCoreSim \
	&& ./obj_dir/rvCoreSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "Verification passed" sim.log && exit 0 || exit 1
